//--- adc_udp_pkg.sv
package adc_udp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and types
    //////////////////////////////////////////////////////////////////////

    localparam int ADC_WIDTH = 10;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [47:0] mac_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Network constants
    //////////////////////////////////////////////////////////////////////

    localparam mac_addr_t   LOCAL_MAC      = 48'h02_00_00_00_00_00;
    localparam mac_addr_t   DEST_MAC       = 48'hc8_a3_62_c9_95_7b;
    localparam ip_addr_t    LOCAL_IP       = {8'd192, 8'd168, 8'd1, 8'd128};
    // Last octet comes from the switches
    localparam logic [23:0] DEST_IP_PREFIX = {8'd192, 8'd168, 8'd1};

    localparam logic [15:0] UDP_SRC_PORT   = 16'd1234;
    localparam logic [15:0] UDP_DST_PORT   = 16'd9999;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // 14 Ethernet + 20 IPv4 + 8 UDP
    localparam int HDR_BYTES = 42;

    //////////////////////////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_TICK,
        CAP_HIGH_BYTE,
        CAP_LOW_BYTE
    } capture_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LATCH,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_t;

    // One's-complement sum over the IPv4 header words, checksum field as zero
    function automatic logic [15:0] ip_checksum(input logic [15:0] total_len,
                                                input ip_addr_t dst);
        logic [19:0] sum;
        sum = 20'h04500 + total_len + {IP_TTL, IP_PROTO_UDP}
            + LOCAL_IP[31:16] + LOCAL_IP[15:0] + dst[31:16] + dst[15:0];
        // Two folds cover any carry out of the first
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        return ~sum[15:0];
    endfunction

endpackage

//--- seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder #(
    parameter bit INVERT = 1'b1
) (
    input  logic [3:0] digit,
    output logic [6:0] segments
);

    logic [6:0] pattern;

    // Segment order gfedcba
    always_comb begin
        case (digit)
            4'h0: pattern = 7'h3f;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5b;
            4'h3: pattern = 7'h4f;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6d;
            4'h6: pattern = 7'h7d;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7f;
            4'h9: pattern = 7'h6f;
            4'ha: pattern = 7'h77;
            4'hb: pattern = 7'h7c;
            4'hc: pattern = 7'h39;
            4'hd: pattern = 7'h5e;
            4'he: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    // Active-low displays need the complement
    assign segments = INVERT ? ~pattern : pattern;

endmodule

//--- adc_sampler.sv
`timescale 1ns/1ps

module adc_sampler import adc_udp_pkg::*; #(
    parameter int PAYLOAD_SAMPLES = 8,
    parameter int ADC_DIV         = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 stop,
    input  logic [ADC_WIDTH-1:0] x,
    input  logic                 smp_ready,
    output logic                 adc_clk,
    output byte_t                smp_data,
    output logic                 smp_valid,
    output logic                 smp_last
);

    localparam int HALF  = ADC_DIV / 2;
    localparam int DIV_W = $clog2(ADC_DIV);
    localparam int CNT_W = (PAYLOAD_SAMPLES > 1) ? $clog2(PAYLOAD_SAMPLES) : 1;

    capture_state_t       state;
    logic [DIV_W-1:0]     div_cnt;
    logic [CNT_W-1:0]     sample_cnt;
    logic                 stop_req;
    logic [ADC_WIDTH-1:0] sample;
    logic                 running;
    logic                 tick;

    assign running = (state != CAP_IDLE);

    // ADC clock high in the first half of the period
    assign adc_clk = running && (div_cnt < DIV_W'(HALF));

    // Falling edge of adc_clk happens on this edge
    assign tick = running && (div_cnt == DIV_W'(HALF - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (!running || div_cnt == DIV_W'(ADC_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte stream
    //////////////////////////////////////////////////////////////////////

    assign smp_valid = (state == CAP_HIGH_BYTE) || (state == CAP_LOW_BYTE);
    assign smp_data  = (state == CAP_HIGH_BYTE) ?
                       {{(16 - ADC_WIDTH){1'b0}}, sample[ADC_WIDTH-1:8]} : sample[7:0];
    assign smp_last  = (state == CAP_LOW_BYTE) &&
                       (sample_cnt == CNT_W'(PAYLOAD_SAMPLES - 1));

    always_ff @(posedge clk) begin
        if (state == CAP_WAIT_TICK && tick) begin
            sample <= x;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= CAP_IDLE;
            sample_cnt <= '0;
            stop_req   <= 1'b0;
        end else begin
            // Stop only takes effect at a frame boundary
            if (running && stop) begin
                stop_req <= 1'b1;
            end
            case (state)
                CAP_IDLE: begin
                    stop_req   <= 1'b0;
                    sample_cnt <= '0;
                    if (start) begin
                        state <= CAP_WAIT_TICK;
                    end
                end
                CAP_WAIT_TICK: begin
                    if (tick) begin
                        state <= CAP_HIGH_BYTE;
                    end
                end
                CAP_HIGH_BYTE: begin
                    if (smp_ready) begin
                        state <= CAP_LOW_BYTE;
                    end
                end
                CAP_LOW_BYTE: begin
                    if (smp_ready) begin
                        if (smp_last) begin
                            sample_cnt <= '0;
                            state      <= (stop_req || stop) ? CAP_IDLE : CAP_WAIT_TICK;
                        end else begin
                            sample_cnt <= sample_cnt + 1'b1;
                            state      <= CAP_WAIT_TICK;
                        end
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

endmodule

//--- frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo import adc_udp_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t smp_data,
    input  logic  smp_valid,
    input  logic  smp_last,
    input  logic  fifo_ready,
    output logic  smp_ready,
    output byte_t fifo_data,
    output logic  fifo_valid,
    output logic  fifo_last
);

    // Depth is a power of two, pointers carry one extra wrap bit
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [8:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_en;
    logic        rd_en;
    logic [8:0]  rd_word;

    assign full      = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign smp_ready = !full;
    assign wr_en     = smp_valid && !full;

    // Only bytes of finished frames are visible to the reader
    assign fifo_valid = (commit_ptr != rd_ptr);
    assign rd_en      = fifo_valid && fifo_ready;
    assign rd_word    = mem[rd_ptr[AW-1:0]];
    assign fifo_data  = rd_word[7:0];
    assign fifo_last  = rd_word[8];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {smp_last, smp_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (smp_last) begin
                commit_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- udp_frame_tx.sv
`timescale 1ns/1ps

module udp_frame_tx import adc_udp_pkg::*; #(
    parameter int PAYLOAD_SAMPLES = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  byte_t    sw_octet,
    input  byte_t    fifo_data,
    input  logic     fifo_valid,
    input  logic     fifo_last,
    input  logic     tx_ready,
    output logic     fifo_ready,
    output byte_t    tx_data,
    output logic     tx_valid,
    output logic     tx_last,
    output logic     hdr_latch,
    output ip_addr_t dest_ip,
    output logic     first_payload
);

    localparam int          FRAME_BYTES  = HDR_BYTES + 2 * PAYLOAD_SAMPLES;
    localparam int          IDX_W        = $clog2(FRAME_BYTES);
    localparam logic [15:0] IP_TOTAL_LEN = 16'(28 + 2 * PAYLOAD_SAMPLES);
    localparam logic [15:0] UDP_LEN      = 16'(8 + 2 * PAYLOAD_SAMPLES);

    tx_state_t              state;
    logic [IDX_W-1:0]       byte_idx;
    logic [15:0]            checksum_q;
    logic [HDR_BYTES*8-1:0] hdr_vec;
    byte_t                  hdr_byte;
    ip_addr_t               next_ip;
    logic                   xfer;

    assign next_ip = {DEST_IP_PREFIX, sw_octet};

    //////////////////////////////////////////////////////////////////////
    // Header fields, first byte on the wire in the top bits
    //////////////////////////////////////////////////////////////////////

    assign hdr_vec = {
        DEST_MAC, LOCAL_MAC, ETHERTYPE_IPV4,
        8'h45, 8'h00, IP_TOTAL_LEN,
        16'h0000, 16'h0000,
        IP_TTL, IP_PROTO_UDP, checksum_q,
        LOCAL_IP, dest_ip,
        UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN, 16'h0000
    };

    always_comb begin
        hdr_byte = '0;
        for (int i = 0; i < HDR_BYTES; i++) begin
            if (byte_idx == IDX_W'(i)) begin
                hdr_byte = hdr_vec[8*(HDR_BYTES-1-i) +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stream
    //////////////////////////////////////////////////////////////////////

    assign tx_valid   = (state == TX_HEADER) || (state == TX_PAYLOAD && fifo_valid);
    assign tx_data    = (state == TX_PAYLOAD) ? fifo_data : hdr_byte;
    assign tx_last    = (state == TX_PAYLOAD) && fifo_last;
    assign fifo_ready = (state == TX_PAYLOAD) && tx_ready;
    assign xfer       = tx_valid && tx_ready;

    assign first_payload = (state == TX_PAYLOAD) && xfer &&
                           (byte_idx == IDX_W'(HDR_BYTES));

    always_ff @(posedge clk) begin
        if (state == TX_LATCH) begin
            checksum_q <= ip_checksum(IP_TOTAL_LEN, next_ip);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            byte_idx  <= '0;
            dest_ip   <= '0;
            hdr_latch <= 1'b0;
        end else begin
            // Pulse lines up with the new dest_ip value
            hdr_latch <= (state == TX_LATCH);
            case (state)
                TX_IDLE: begin
                    if (fifo_valid) begin
                        state <= TX_LATCH;
                    end
                end
                TX_LATCH: begin
                    dest_ip  <= next_ip;
                    byte_idx <= '0;
                    state    <= TX_HEADER;
                end
                TX_HEADER: begin
                    if (xfer) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == IDX_W'(HDR_BYTES - 1)) begin
                            state <= TX_PAYLOAD;
                        end
                    end
                end
                TX_PAYLOAD: begin
                    if (xfer) begin
                        if (fifo_last) begin
                            state <= TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- status_display.sv
`timescale 1ns/1ps

module status_display import adc_udp_pkg::*; #(
    parameter bit INVERT = 1'b1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hdr_latch,
    input  ip_addr_t   dest_ip,
    input  logic       first_payload,
    input  byte_t      tx_data,
    output byte_t      ledg,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5,
    output logic [6:0] hex6,
    output logic [6:0] hex7
);

    ip_addr_t   ip_q;
    logic [6:0] seg [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            ledg <= '0;
            ip_q <= '0;
        end else begin
            if (first_payload) begin
                ledg <= tx_data;
            end
            if (hdr_latch) begin
                ip_q <= dest_ip;
            end
        end
    end

    // One decoder per nibble, digit 0 is the low nibble
    for (genvar n = 0; n < 8; n++) begin : g_digit
        seg7_decoder #(
            .INVERT(INVERT)
        ) seg7_decoder_inst (
            .digit(ip_q[4*n +: 4]),
            .segments(seg[n])
        );
    end

    assign hex0 = seg[0];
    assign hex1 = seg[1];
    assign hex2 = seg[2];
    assign hex3 = seg[3];
    assign hex4 = seg[4];
    assign hex5 = seg[5];
    assign hex6 = seg[6];
    assign hex7 = seg[7];

endmodule

//--- adc_udp_core.sv
`timescale 1ns/1ps

module adc_udp_core import adc_udp_pkg::*; #(
    parameter int PAYLOAD_SAMPLES = 8,
    parameter int ADC_DIV         = 4,
    parameter int FIFO_DEPTH      = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADC_WIDTH-1:0] x,
    input  logic                 start,
    input  logic                 stop,
    input  logic [7:0]           sw,
    input  logic                 tx_ready,
    output logic                 adc_clk,
    output byte_t                tx_data,
    output logic                 tx_valid,
    output logic                 tx_last,
    output byte_t                ledg,
    output logic [6:0]           hex0,
    output logic [6:0]           hex1,
    output logic [6:0]           hex2,
    output logic [6:0]           hex3,
    output logic [6:0]           hex4,
    output logic [6:0]           hex5,
    output logic [6:0]           hex6,
    output logic [6:0]           hex7
);

    // Sampler to FIFO
    byte_t    smp_data;
    logic     smp_valid;
    logic     smp_last;
    logic     smp_ready;

    // FIFO to frame builder
    byte_t    fifo_data;
    logic     fifo_valid;
    logic     fifo_last;
    logic     fifo_ready;

    // Status
    logic     hdr_latch;
    ip_addr_t dest_ip;
    logic     first_payload;

    adc_sampler #(
        .PAYLOAD_SAMPLES(PAYLOAD_SAMPLES),
        .ADC_DIV(ADC_DIV)
    ) adc_sampler_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .stop(stop),
        .x(x),
        .smp_ready(smp_ready),
        .adc_clk(adc_clk),
        .smp_data(smp_data),
        .smp_valid(smp_valid),
        .smp_last(smp_last)
    );

    frame_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) frame_fifo_inst (
        .clk(clk),
        .rst(rst),
        .smp_data(smp_data),
        .smp_valid(smp_valid),
        .smp_last(smp_last),
        .fifo_ready(fifo_ready),
        .smp_ready(smp_ready),
        .fifo_data(fifo_data),
        .fifo_valid(fifo_valid),
        .fifo_last(fifo_last)
    );

    udp_frame_tx #(
        .PAYLOAD_SAMPLES(PAYLOAD_SAMPLES)
    ) udp_frame_tx_inst (
        .clk(clk),
        .rst(rst),
        .sw_octet(sw),
        .fifo_data(fifo_data),
        .fifo_valid(fifo_valid),
        .fifo_last(fifo_last),
        .tx_ready(tx_ready),
        .fifo_ready(fifo_ready),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_last(tx_last),
        .hdr_latch(hdr_latch),
        .dest_ip(dest_ip),
        .first_payload(first_payload)
    );

    status_display #(
        .INVERT(1'b1)
    ) status_display_inst (
        .clk(clk),
        .rst(rst),
        .hdr_latch(hdr_latch),
        .dest_ip(dest_ip),
        .first_payload(first_payload),
        .tx_data(tx_data),
        .ledg(ledg),
        .hex0(hex0),
        .hex1(hex1),
        .hex2(hex2),
        .hex3(hex3),
        .hex4(hex4),
        .hex5(hex5),
        .hex6(hex6),
        .hex7(hex7)
    );

endmodule

//--- adc_udp_core_properties.sv
`timescale 1ns/1ps

module adc_udp_core_properties import adc_udp_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  tx_valid,
    input logic  tx_ready,
    input byte_t tx_data,
    input logic  tx_last
);

    int assert_errors = 0;

    // A stalled byte keeps its data and last flag
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> ($stable(tx_data) && $stable(tx_last)))
        else begin
            $error("tx_data or tx_last changed while the stream was stalled");
            assert_errors++;
        end

    // Valid only drops after a transfer
    valid_held: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> tx_valid)
        else begin
            $error("tx_valid fell without a transfer");
            assert_errors++;
        end

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        tx_last |-> tx_valid)
        else begin
            $error("tx_last high without tx_valid");
            assert_errors++;
        end

endmodule

bind udp_frame_tx adc_udp_core_properties adc_udp_core_properties_inst (
    .clk(clk),
    .rst(rst),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .tx_data(tx_data),
    .tx_last(tx_last)
);

//--- tb_adc_udp_core.sv
`timescale 1ns/1ps

module tb_adc_udp_core import adc_udp_pkg::*;;

    localparam int PAYLOAD_SAMPLES = 8;
    localparam int ADC_DIV         = 4;
    localparam int FIFO_DEPTH      = 64;
    localparam int FRAME_BYTES     = HDR_BYTES + 2 * PAYLOAD_SAMPLES;
    localparam int QUIET_CYCLES    = 10 * FRAME_BYTES * ADC_DIV;
    localparam logic [15:0] IP_LEN  = 16'(20 + 8 + 2 * PAYLOAD_SAMPLES);
    localparam logic [15:0] UDP_LEN = 16'(8 + 2 * PAYLOAD_SAMPLES);
    localparam logic [31:0] LFSR_SEED = 32'hb6a9_d779;

    // Segments lit per hex digit in gfedcba order
    localparam logic [6:0] SEG_ON [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
        7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    typedef struct packed {
        logic [ADC_WIDTH-1:0] x;
        byte_t                sw;
        logic [3:0]           frames;
        logic                 backpressure;
    } stim_row_t;

    localparam int NUM_ROWS = 5;
    localparam stim_row_t ROWS [NUM_ROWS] = '{
        '{10'h2a5, 8'h37, 4'd2, 1'b0},
        '{10'h2a5, 8'h37, 4'd2, 1'b1},
        '{10'h3ff, 8'hff, 4'd3, 1'b0},
        '{10'h001, 8'h00, 4'd1, 1'b0},
        '{10'h15a, 8'hc4, 4'd4, 1'b1}
    };

    logic                 clk;
    logic                 rst;
    logic [ADC_WIDTH-1:0] x;
    logic                 start;
    logic                 stop;
    logic [7:0]           sw;
    logic                 tx_ready;
    logic                 adc_clk;
    byte_t                tx_data;
    logic                 tx_valid;
    logic                 tx_last;
    byte_t                ledg;
    logic [6:0]           hex [8];

    logic  bp_mode;
    byte_t exp_frame [FRAME_BYTES];
    int    byte_pos      = 0;
    int    tx_frames     = 0;
    int    smp_frames    = 0;
    int    stream_errors = 0;
    int    main_errors;

    adc_udp_core #(
        .PAYLOAD_SAMPLES(PAYLOAD_SAMPLES),
        .ADC_DIV(ADC_DIV),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) adc_udp_core_inst (
        .clk(clk),
        .rst(rst),
        .x(x),
        .start(start),
        .stop(stop),
        .sw(sw),
        .tx_ready(tx_ready),
        .adc_clk(adc_clk),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_last(tx_last),
        .ledg(ledg),
        .hex0(hex[0]),
        .hex1(hex[1]),
        .hex2(hex[2]),
        .hex3(hex[3]),
        .hex4(hex[4]),
        .hex5(hex[5]),
        .hex6(hex[6]),
        .hex7(hex[7])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference frame for one row
    //////////////////////////////////////////////////////////////////////

    task automatic build_frame(input logic [ADC_WIDTH-1:0] xv, input byte_t swv);
        logic [31:0] acc;
        ip_addr_t    dst;
        dst = {DEST_IP_PREFIX, swv};
        for (int i = 0; i < 6; i++) begin
            exp_frame[i]     = DEST_MAC[47 - 8 * i -: 8];
            exp_frame[6 + i] = LOCAL_MAC[47 - 8 * i -: 8];
        end
        exp_frame[12] = ETHERTYPE_IPV4[15:8];
        exp_frame[13] = ETHERTYPE_IPV4[7:0];
        exp_frame[14] = 8'h45;
        exp_frame[15] = 8'h00;
        exp_frame[16] = IP_LEN[15:8];
        exp_frame[17] = IP_LEN[7:0];
        for (int i = 18; i < 22; i++) begin
            exp_frame[i] = 8'h00;
        end
        exp_frame[22] = IP_TTL;
        exp_frame[23] = IP_PROTO_UDP;
        exp_frame[24] = 8'h00;
        exp_frame[25] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            exp_frame[26 + i] = LOCAL_IP[31 - 8 * i -: 8];
            exp_frame[30 + i] = dst[31 - 8 * i -: 8];
        end
        exp_frame[34] = UDP_SRC_PORT[15:8];
        exp_frame[35] = UDP_SRC_PORT[7:0];
        exp_frame[36] = UDP_DST_PORT[15:8];
        exp_frame[37] = UDP_DST_PORT[7:0];
        exp_frame[38] = UDP_LEN[15:8];
        exp_frame[39] = UDP_LEN[7:0];
        exp_frame[40] = 8'h00;
        exp_frame[41] = 8'h00;
        // Sum of the ten header words with end-around carry
        acc = '0;
        for (int i = 14; i < 34; i += 2) begin
            acc = acc + {16'd0, exp_frame[i], exp_frame[i + 1]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        exp_frame[24] = ~acc[15:8];
        exp_frame[25] = ~acc[7:0];
        for (int k = 0; k < PAYLOAD_SAMPLES; k++) begin
            exp_frame[HDR_BYTES + 2 * k]     = {6'd0, xv[9:8]};
            exp_frame[HDR_BYTES + 2 * k + 1] = xv[7:0];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream monitor and display checks
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        ip_addr_t dst;
        if (!rst && tx_valid && tx_ready) begin
            if (tx_data !== exp_frame[byte_pos]) begin
                $display("Fail tx_data byte %0d: got %h, expected %h",
                         byte_pos, tx_data, exp_frame[byte_pos]);
                stream_errors++;
            end
            if (tx_last !== (byte_pos == FRAME_BYTES - 1)) begin
                $display("Fail tx_last byte %0d: got %h, expected %h",
                         byte_pos, tx_last, byte_pos == FRAME_BYTES - 1);
                stream_errors++;
            end
            if (byte_pos == FRAME_BYTES - 1) begin
                byte_pos = 0;
                tx_frames++;
                if (ledg !== exp_frame[HDR_BYTES]) begin
                    $display("Fail ledg: got %h, expected %h", ledg, exp_frame[HDR_BYTES]);
                    stream_errors++;
                end
                dst = {exp_frame[30], exp_frame[31], exp_frame[32], exp_frame[33]};
                for (int n = 0; n < 8; n++) begin
                    if (hex[n] !== ~SEG_ON[dst[4 * n +: 4]]) begin
                        $display("Fail hex%0d: got %h, expected %h",
                                 n, hex[n], ~SEG_ON[dst[4 * n +: 4]]);
                        stream_errors++;
                    end
                end
            end else begin
                byte_pos++;
            end
        end
    end

    // Frames leaving the sampler time the stop pulse
    always @(negedge clk) begin
        if (!rst && adc_udp_core_inst.smp_valid && adc_udp_core_inst.smp_ready &&
            adc_udp_core_inst.smp_last) begin
            smp_frames++;
        end
    end

    initial begin
        logic [31:0] lfsr;
        lfsr = LFSR_SEED;
        tx_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (bp_mode) begin
                lfsr = lfsr_step(lfsr);
                tx_ready = lfsr[0];
            end else begin
                tx_ready = 1'b1;
            end
        end
    end

    initial begin
        int limit;
        int total_frames;
        int cycles;
        total_frames = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_frames += int'(ROWS[r].frames);
        end
        limit = total_frames * FRAME_BYTES * ADC_DIV * 4 + NUM_ROWS * QUIET_CYCLES + 2000;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the expected frames never all arrived", cycles);
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int   tx_base;
        int   smp_base;
        int   prop_errors;
        logic quiet_ok;
        rst         = 1'b1;
        start       = 1'b0;
        stop        = 1'b0;
        x           = '0;
        sw          = '0;
        bp_mode     = 1'b0;
        main_errors = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (tx_valid !== 1'b0 || tx_last !== 1'b0 || adc_clk !== 1'b0) begin
            $display("Fail tx_valid/tx_last/adc_clk after reset: got %h%h%h, expected 000",
                     tx_valid, tx_last, adc_clk);
            main_errors++;
        end
        if (ledg !== 8'h00) begin
            $display("Fail ledg after reset: got %h, expected 00", ledg);
            main_errors++;
        end
        for (int n = 0; n < 8; n++) begin
            if (hex[n] !== ~SEG_ON[0]) begin
                $display("Fail hex%0d after reset: got %h, expected %h", n, hex[n], ~SEG_ON[0]);
                main_errors++;
            end
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1;
            x       = ROWS[r].x;
            sw      = ROWS[r].sw;
            bp_mode = ROWS[r].backpressure;
            build_frame(ROWS[r].x, ROWS[r].sw);
            tx_base  = tx_frames;
            smp_base = smp_frames;
            start    = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            // Stop lands inside the last frame of the row
            while (smp_frames - smp_base < int'(ROWS[r].frames) - 1) begin
                @(posedge clk);
                #1;
            end
            stop = 1'b1;
            @(posedge clk);
            #1;
            stop = 1'b0;
            while (tx_frames - tx_base < int'(ROWS[r].frames)) begin
                @(posedge clk);
            end
            quiet_ok = 1'b1;
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (tx_valid !== 1'b0 || adc_clk !== 1'b0) begin
                    quiet_ok = 1'b0;
                end
            end
            if (!quiet_ok) begin
                $display("Row %0d kept sending or sampling after its stop", r);
                main_errors++;
            end
            if (tx_frames - tx_base != int'(ROWS[r].frames)) begin
                $display("Row %0d sent %0d frames instead of %0d",
                         r, tx_frames - tx_base, ROWS[r].frames);
                main_errors++;
            end
        end
        prop_errors =
            adc_udp_core_inst.udp_frame_tx_inst.adc_udp_core_properties_inst.assert_errors;
        $display("Errors: %0d in stream checks, %0d in control checks, %0d in assertions",
                 stream_errors, main_errors, prop_errors);
        if (stream_errors == 0 && main_errors == 0 && prop_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog.f
adc_udp_pkg.sv
seg7_decoder.sv
adc_sampler.sv
frame_fifo.sv
udp_frame_tx.sv
status_display.sv
adc_udp_core.sv
adc_udp_core_properties.sv
tb_adc_udp_core.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_udp_core \
    -f verilog.f -o tb_adc_udp_core > build.log 2>&1 &&
    ./obj_dir/tb_adc_udp_core > sim.log 2>&1 ||
    echo "Build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qs "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
